//--- Bender.yml
package:
  name: srt_divider

sources:
  - divFormatPkg.sv
  - divSelectPkg.sv
  - divStageIf.sv
  - divNormalize.sv
  - divDigitSelect.sv
  - divOnTheFly.sv
  - divStage.sv
  - divider.sv
  - target: simulation
    files:
      - divClockGen.sv
      - divider_asserts.sv
      - dividerTb.sv

//--- divClockGen.sv
// Clock and reset source for the divider testbench.
// Reset_n is released on a falling edge after ResetCycles rising edges.
`timescale 1ns/100ps
`default_nettype none

module divClockGen #(
  parameter int Period      = 40,
  parameter int ResetCycles = 8
) (
  output logic Clk,
  output logic Reset_n
);

  initial
  begin
    Clk = 1'b0;
    forever #(Period / 2) Clk = ~Clk;
  end

  initial
  begin
    Reset_n = 1'b0;
    repeat (ResetCycles) @(posedge Clk);
    @(negedge Clk);
    Reset_n = 1'b1;
  end

endmodule : divClockGen

`default_nettype wire

//--- divDigitSelect.sv
// One radix-4 SRT step: picks a digit in {-2..+2} from a truncated estimate
// of 4w and forms the next residual 4w - q*d. Purely combinational.
`timescale 1ns/100ps
`default_nettype none

module divDigitSelect #(
  parameter int FracWidth = 9
) (
  input  logic [FracWidth+divFormatPkg::GuardBits:0]            divisor,
  input  logic signed [FracWidth+divFormatPkg::ResidualExtra-1:0] residual,
  output divSelectPkg::qDigit_e                                  digit,
  output logic signed [FracWidth+divFormatPkg::ResidualExtra-1:0] nextResidual
);
  import divFormatPkg::*;
  import divSelectPkg::*;

  localparam int OpWidth  = FracWidth + GuardBits + 1;
  localparam int ResWidth = FracWidth + ResidualExtra;

  logic signed [ResWidth+1:0] times4;
  logic signed [ResWidth+1:0] divisorExt;
  logic signed [ResWidth+1:0] difference;
  logic signed [2:0]          digitVal;
  threshold_t                 estimate;
  selectThresh_t              thresh;

  assign times4     = {residual, 2'b00};
  assign divisorExt = {{(ResWidth + 2 - OpWidth){1'b0}}, divisor};

  // seven top bits, LSB weight 1/16
  assign estimate = times4[ResWidth+1 -: 7];
  assign thresh   = selectThresholds(divisor[OpWidth-2 -: 3]);

  always_comb
  begin
    if (estimate >= thresh.m2)
      digit = DigitP2;
    else if (estimate >= thresh.m1)
      digit = DigitP1;
    else if (estimate >= thresh.m0)
      digit = Digit0;
    else if (estimate >= thresh.mm1)
      digit = DigitM1;
    else
      digit = DigitM2;
  end

  assign digitVal   = digit;
  assign difference = times4 - digitVal * divisorExt;

  // |w| stays below 2d/3, so the top two bits carry no information
  assign nextResidual = difference[ResWidth-1:0];

endmodule : divDigitSelect

`default_nettype wire

//--- divFormatPkg.sv
// Number formats and pipeline geometry of the radix-4 SRT divider.
// Imported by every RTL block and by the testbench.
`default_nettype none

package divFormatPkg;

  // radix-4 digits retired per recurrence stage
  localparam int DigitsPerStage = 2;

  // recurrence stages after normalization
  localparam int NumStages = 3;

  // operand bits above the fraction, operands are FracWidth + 5 wide
  localparam int GuardBits = 4;

  // residual bits above FracWidth
  // room for the sign and for 4x growth before truncation
  localparam int ResidualExtra = 6;

  // normalize register plus one register per stage
  localparam int Latency = NumStages + 1;

  // converted quotient, two bits per digit
  localparam int QuotBits = 2 * NumStages * DigitsPerStage;

endpackage : divFormatPkg

`default_nettype wire

//--- divNormalize.sv
// Input stage of the divider: shifts the divisor into [0.5, 1) and the
// dividend by the same amount, then registers the first pipeline item.
`timescale 1ns/100ps
`default_nettype none

module divNormalize #(
  parameter int FracWidth = 9
) (
  input  logic                                        Clk,
  input  logic                                        Reset_n,
  input  logic                                        inValid,
  input  logic [FracWidth+divFormatPkg::GuardBits:0]  dividend,
  input  logic [FracWidth+divFormatPkg::GuardBits:0]  divisor,
  divStageIf.src                                      out
);
  import divFormatPkg::*;

  localparam int OpWidth    = FracWidth + GuardBits + 1;
  localparam int ResWidth   = FracWidth + ResidualExtra;
  localparam int ShiftWidth = $clog2(OpWidth);

  logic [ShiftWidth-1:0] shiftCount;
  logic [OpWidth-1:0]    normDivisor;
  logic [OpWidth-1:0]    normDividend;
  logic [ResWidth-1:0]   firstResidual;

  // leading one search, the highest set bit wins
  always_comb
  begin
    shiftCount = '0;
    for (int i = 0; i < OpWidth; i++)
    begin
      if (divisor[i])
        shiftCount = ShiftWidth'(OpWidth - 1 - i);
    end
  end

  assign normDivisor  = divisor << shiftCount;
  assign normDividend = dividend << shiftCount;

  // w0 = x/4 keeps |w| below 2d/3
  assign firstResidual = {1'b0, normDividend} >> 2;

  always_ff @(posedge Clk or negedge Reset_n)
  begin
    if (!Reset_n)
      out.valid <= 1'b0;
    else
      out.valid <= inValid;
  end

  always_ff @(posedge Clk)
  begin
    if (inValid)
    begin
      out.divisor  <= normDivisor;
      out.residual <= $signed(firstResidual);
      out.quotN    <= '0;
      out.quotM    <= '0;
    end
  end

endmodule : divNormalize

`default_nettype wire

//--- divOnTheFly.sv
// On-the-fly conversion of one signed radix-4 digit.
// Keeps QN = Q and QM = Q - 1 so no carry ever propagates.
`timescale 1ns/100ps
`default_nettype none

module divOnTheFly (
  input  divSelectPkg::qDigit_e                digit,
  input  logic [divFormatPkg::QuotBits-1:0]    quotN,
  input  logic [divFormatPkg::QuotBits-1:0]    quotM,
  output logic [divFormatPkg::QuotBits-1:0]    nextN,
  output logic [divFormatPkg::QuotBits-1:0]    nextM
);
  import divFormatPkg::*;
  import divSelectPkg::*;

  logic       isNeg;
  logic       isPos;
  logic [1:0] digitLow;
  logic [1:0] digitLess1;

  assign isNeg      = digit[2];
  assign isPos      = !digit[2] && (digit != Digit0);
  assign digitLow   = digit[1:0];
  assign digitLess1 = digit[1:0] - 2'd1;

  // older digits move up two places
  assign nextN = isNeg ? {quotM[QuotBits-3:0], digitLow}
                       : {quotN[QuotBits-3:0], digitLow};

  assign nextM = isPos ? {quotN[QuotBits-3:0], digitLess1}
                       : {quotM[QuotBits-3:0], digitLess1};

endmodule : divOnTheFly

`default_nettype wire

//--- divSelectPkg.sv
// Quotient digit type and selection thresholds for the radix-4 recurrence.
// Used by the digit selection and the on-the-fly conversion.
`default_nettype none

package divSelectPkg;

  typedef enum logic signed [2:0] {
    DigitM2 = -3'sd2,
    DigitM1 = -3'sd1,
    Digit0  = 3'sd0,
    DigitP1 = 3'sd1,
    DigitP2 = 3'sd2
  } qDigit_e;

  // estimate units of 1/16
  typedef logic signed [6:0] threshold_t;

  typedef struct packed {
    threshold_t m2;
    threshold_t m1;
    threshold_t m0;
    threshold_t mm1;
  } selectThresh_t;

  // dBits are the three divisor bits below the leading one
  function automatic selectThresh_t selectThresholds(input logic [2:0] dBits);
    selectThresh_t thresh;
    case (dBits)
      3'b000:  thresh = '{m2: 7'sd12, m1: 7'sd4, m0: -7'sd4, mm1: -7'sd13};
      3'b001:  thresh = '{m2: 7'sd14, m1: 7'sd4, m0: -7'sd6, mm1: -7'sd15};
      3'b010:  thresh = '{m2: 7'sd15, m1: 7'sd4, m0: -7'sd6, mm1: -7'sd16};
      3'b011:  thresh = '{m2: 7'sd16, m1: 7'sd4, m0: -7'sd6, mm1: -7'sd18};
      3'b100:  thresh = '{m2: 7'sd18, m1: 7'sd6, m0: -7'sd8, mm1: -7'sd20};
      3'b101:  thresh = '{m2: 7'sd20, m1: 7'sd6, m0: -7'sd8, mm1: -7'sd20};
      3'b110:  thresh = '{m2: 7'sd20, m1: 7'sd8, m0: -7'sd8, mm1: -7'sd22};
      default: thresh = '{m2: 7'sd24, m1: 7'sd8, m0: -7'sd8, mm1: -7'sd24};
    endcase
    return thresh;
  endfunction

endpackage : divSelectPkg

`default_nettype wire

//--- divStage.sv
// One recurrence stage of the divider: two digit selections and their
// conversions in one cycle, followed by the stage register.
`timescale 1ns/100ps
`default_nettype none

module divStage #(
  parameter int FracWidth = 9
) (
  input  logic   Clk,
  input  logic   Reset_n,
  divStageIf.dst in,
  divStageIf.src out
);
  import divFormatPkg::*;
  import divSelectPkg::*;

  localparam int ResWidth = FracWidth + ResidualExtra;

  logic signed [ResWidth-1:0] residualChain [DigitsPerStage+1];
  logic [QuotBits-1:0]        quotNChain    [DigitsPerStage+1];
  logic [QuotBits-1:0]        quotMChain    [DigitsPerStage+1];
  qDigit_e                    digitChain    [DigitsPerStage];

  assign residualChain[0] = in.residual;
  assign quotNChain[0]    = in.quotN;
  assign quotMChain[0]    = in.quotM;

  // each step feeds the next within the same cycle
  for (genvar k = 0; k < DigitsPerStage; k++)
  begin : gStep
    divDigitSelect #(
      .FracWidth    (FracWidth)
    ) uSelect (
      .divisor      (in.divisor),
      .residual     (residualChain[k]),
      .digit        (digitChain[k]),
      .nextResidual (residualChain[k+1])
    );

    divOnTheFly uConvert (
      .digit (digitChain[k]),
      .quotN (quotNChain[k]),
      .quotM (quotMChain[k]),
      .nextN (quotNChain[k+1]),
      .nextM (quotMChain[k+1])
    );
  end

  always_ff @(posedge Clk or negedge Reset_n)
  begin
    if (!Reset_n)
      out.valid <= 1'b0;
    else
      out.valid <= in.valid;
  end

  // payload only moves with a valid item
  always_ff @(posedge Clk)
  begin
    if (in.valid)
    begin
      out.divisor  <= in.divisor;
      out.residual <= residualChain[DigitsPerStage];
      out.quotN    <= quotNChain[DigitsPerStage];
      out.quotM    <= quotMChain[DigitsPerStage];
    end
  end

endmodule : divStage

`default_nettype wire

//--- divStageIf.sv
// One divider item moving between pipeline stages.
// A stage takes the item on the edge where valid is high; there is no ready.
`timescale 1ns/100ps
`default_nettype none

interface divStageIf #(
  parameter int FracWidth = 9
);
  import divFormatPkg::*;

  logic                                   valid;
  // normalized, leading one at the top bit
  logic [FracWidth+GuardBits:0]           divisor;
  logic signed [FracWidth+ResidualExtra-1:0] residual;
  logic [QuotBits-1:0]                    quotN;
  logic [QuotBits-1:0]                    quotM;

  modport src (output valid, divisor, residual, quotN, quotM);
  modport dst (input valid, divisor, residual, quotN, quotM);

endinterface : divStageIf

`default_nettype wire

//--- divider.sv
// Top level of the pipelined radix-4 SRT fraction divider.
// Takes x < d, d nonzero; the quotient appears four clocks after inValid.
`timescale 1ns/100ps
`default_nettype none

module divider #(
  parameter int FracWidth = 9
) (
  input  logic                                       Clk,
  input  logic                                       Reset_n,
  input  logic                                       inValid,
  input  logic [FracWidth+divFormatPkg::GuardBits:0] dividend,
  input  logic [FracWidth+divFormatPkg::GuardBits:0] divisor,
  output logic                                       outValid,
  output logic [FracWidth-1:0]                       quotient
);
  import divFormatPkg::*;

  // link[0] leaves normalization, link[NumStages] leaves the last stage
  divStageIf #(.FracWidth(FracWidth)) link [NumStages+1] ();

  divNormalize #(
    .FracWidth (FracWidth)
  ) uNormalize (
    .Clk      (Clk),
    .Reset_n  (Reset_n),
    .inValid  (inValid),
    .dividend (dividend),
    .divisor  (divisor),
    .out      (link[0])
  );

  for (genvar s = 0; s < NumStages; s++)
  begin : gStage
    divStage #(
      .FracWidth (FracWidth)
    ) uStage (
      .Clk     (Clk),
      .Reset_n (Reset_n),
      .in      (link[s]),
      .out     (link[s+1])
    );
  end

  assign outValid = link[NumStages].valid;

  // QN carries one extra fraction bit, dropped here
  assign quotient = link[NumStages].quotN[FracWidth:1];

endmodule : divider

`default_nettype wire

//--- dividerTb.sv
// Testbench for the SRT divider: streams directed and random operands and
// checks every quotient against an exact integer division.
`timescale 1ns/100ps
`default_nettype none

module dividerTb;
  import divFormatPkg::*;

  localparam int FracWidth   = 9;
  localparam int OpWidth     = FracWidth + GuardBits + 1;
  localparam int Period      = 40;
  localparam int ResetCycles = 8;
  localparam int IdleCycles  = 6;
  localparam int NumDirected = 10;
  localparam int BurstCount  = 24;
  localparam int GapCount    = 40;
  localparam int TotalItems  = NumDirected + OpWidth + BurstCount + GapCount;
  // two cycles per item at most, plus reset, idle checks and drain
  localparam int WatchdogCycles = 2 * TotalItems + ResetCycles + IdleCycles
                                  + 3 * Latency + 8;

  localparam logic [OpWidth-1:0] TopBit = OpWidth'(1) << (OpWidth - 1);
  localparam logic [OpWidth-1:0] OpMax  = '1;

  logic                 Clk;
  logic                 Reset_n;
  logic                 inValid;
  logic [OpWidth-1:0]   dividend;
  logic [OpWidth-1:0]   divisor;
  logic                 outValid;
  logic [FracWidth-1:0] quotient;

  integer               seed;
  int                   sentCount;
  int                   resultCount;
  logic [FracWidth-1:0] expectQ [$];

  divClockGen #(
    .Period      (Period),
    .ResetCycles (ResetCycles)
  ) uClock (
    .Clk     (Clk),
    .Reset_n (Reset_n)
  );

  divider #(
    .FracWidth (FracWidth)
  ) uut (
    .Clk      (Clk),
    .Reset_n  (Reset_n),
    .inValid  (inValid),
    .dividend (dividend),
    .divisor  (divisor),
    .outValid (outValid),
    .quotient (quotient)
  );

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValid(input logic expected, input logic actual);
    if (actual !== expected)
      abortRun($sformatf("MISMATCH outValid expected %h actual %h", expected, actual));
  endtask

  // no remainder correction, so the last unit may land one off either way
  task automatic checkQuotient(input logic [FracWidth-1:0] expected,
                               input logic [FracWidth-1:0] actual);
    logic [FracWidth-1:0] below;
    logic [FracWidth-1:0] above;
    below = expected - 1'b1;
    above = expected + 1'b1;
    if (actual !== expected && actual !== below && actual !== above)
      abortRun($sformatf("MISMATCH quotient expected %h actual %h", expected, actual));
  endtask

  // floor(x * 2^FracWidth / d), exact for x < d
  function automatic logic [FracWidth-1:0] refQuotient(input logic [OpWidth-1:0] x,
                                                      input logic [OpWidth-1:0] d);
    logic [OpWidth+FracWidth-1:0] scaled;
    scaled = {x, {FracWidth{1'b0}}};
    return FracWidth'(scaled / d);
  endfunction

  task automatic sendItem(input logic [OpWidth-1:0] x, input logic [OpWidth-1:0] d);
    @(negedge Clk);
    inValid  = 1'b1;
    dividend = x;
    divisor  = d;
    expectQ.push_back(refQuotient(x, d));
    sentCount++;
  endtask

  task automatic idleCycles(input int count);
    repeat (count)
    begin
      @(negedge Clk);
      inValid  = 1'b0;
      dividend = '0;
      divisor  = '0;
    end
  endtask

  task automatic checkIdle(input int count);
    repeat (count)
    begin
      idleCycles(1);
      checkValid(1'b0, outValid);
    end
  endtask

  task automatic randomOperands(output logic [OpWidth-1:0] x,
                                output logic [OpWidth-1:0] d);
    logic [31:0] rnd;
    logic [31:0] spread;
    rnd    = $random(seed);
    spread = $random(seed);
    // up to seven leading zeros
    d = OpWidth'(rnd) >> spread[2:0];
    if (d == '0)
      d = OpWidth'(1);
    rnd = $random(seed);
    x   = OpWidth'(rnd % d);
  endtask

  task automatic runDirected();
    logic [OpWidth-1:0] d;
    d = TopBit | (TopBit >> 1);
    sendItem(d >> 1, d);
    sendItem(OpMax - OpWidth'(1), OpMax);
    sendItem(TopBit - OpWidth'(1), TopBit);
    sendItem(OpWidth'(1), OpMax);
    sendItem(OpWidth'(3), TopBit | OpWidth'(7));
    sendItem(OpWidth'(50), OpWidth'(100));
    sendItem(OpWidth'(0), TopBit);
    sendItem(TopBit, TopBit + OpWidth'(1));
    sendItem(OpWidth'(2), OpWidth'(3));
    sendItem(OpMax >> 2, OpMax >> 1);
  endtask

  // leading one walks from bit 0 to the top, d = 1 forces x = 0
  task automatic runNormalization();
    logic [OpWidth-1:0] lowMask;
    logic [OpWidth-1:0] d;
    logic [31:0]        rnd;
    for (int k = 0; k < OpWidth; k++)
    begin
      lowMask = (OpWidth'(1) << k) - OpWidth'(1);
      rnd     = $random(seed);
      d       = (OpWidth'(1) << k) | (OpWidth'(rnd) & lowMask);
      rnd     = $random(seed);
      sendItem(OpWidth'(rnd % d), d);
    end
  endtask

  task automatic runRandom(input int count, input logic withGaps);
    logic [OpWidth-1:0] x;
    logic [OpWidth-1:0] d;
    logic [31:0]        rnd;
    for (int i = 0; i < count; i++)
    begin
      randomOperands(x, d);
      sendItem(x, d);
      rnd = $random(seed);
      if (withGaps && rnd[0])
        idleCycles(1);
    end
  endtask

  // outputs are read before this edge updates them
  always @(posedge Clk)
  begin
    if (Reset_n && outValid)
    begin
      if (expectQ.size() == 0)
        abortRun("outValid went high although no result was pending");
      else
      begin
        resultCount++;
        checkQuotient(expectQ.pop_front(), quotient);
      end
    end
  end

  // bound port checks on the divider
  always @(uut.uAsserts.failCount)
  begin
    if (uut.uAsserts.failCount != 0)
      abortRun("an assertion on the divider ports failed");
  end

  initial
  begin
    #(WatchdogCycles * Period);
    abortRun("timeout: the divider did not return all results in time");
  end

  initial
  begin
    seed        = 32'h14e1_d210;
    sentCount   = 0;
    resultCount = 0;
    inValid     = 1'b0;
    dividend    = '0;
    divisor     = '0;
    @(posedge Reset_n);
    checkIdle(IdleCycles);
    runDirected();
    runNormalization();
    runRandom(BurstCount, 1'b0);
    runRandom(GapCount, 1'b1);
    idleCycles(1);
    while (expectQ.size() != 0)
      @(negedge Clk);
    // idle input, so nothing more may come out
    checkIdle(Latency + 2);
    if (resultCount == sentCount && expectQ.size() == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
      abortRun("number of results differs from the number of accepted inputs");
  end

endmodule : dividerTb

`default_nettype wire

//--- divider_asserts.sv
// Concurrent checks on the divider ports.
// Bound into every divider instance by the bind at the end of this file.
`timescale 1ns/100ps
`default_nettype none

module dividerAsserts #(
  parameter int FracWidth = 9
) (
  input logic                 Clk,
  input logic                 Reset_n,
  input logic                 inValid,
  input logic                 outValid,
  input logic [FracWidth-1:0] quotient
);
  import divFormatPkg::*;

  // number of failed assertions
  int failCount = 0;

  // each accepted item leaves exactly Latency edges later
  property validLatency;
    @(posedge Clk) disable iff (!Reset_n)
      outValid == $past(inValid, Latency);
  endproperty

  property quietInReset;
    @(posedge Clk) !Reset_n |-> !outValid;
  endproperty

  property quotientKnown;
    @(posedge Clk) disable iff (!Reset_n)
      outValid |-> !$isunknown(quotient);
  endproperty

  assertLatency: assert property (validLatency)
    else
    begin
      failCount++;
      $error("outValid does not follow inValid by %0d cycles", Latency);
    end

  assertQuietInReset: assert property (quietInReset)
    else
    begin
      failCount++;
      $error("outValid is high while Reset_n is low");
    end

  assertQuotientKnown: assert property (quotientKnown)
    else
    begin
      failCount++;
      $error("quotient has X or Z bits while outValid is high");
    end

endmodule : dividerAsserts

bind divider dividerAsserts #(
  .FracWidth (FracWidth)
) uAsserts (
  .Clk      (Clk),
  .Reset_n  (Reset_n),
  .inValid  (inValid),
  .outValid (outValid),
  .quotient (quotient)
);

`default_nettype wire

//--- vlog.f
divFormatPkg.sv
divSelectPkg.sv
divStageIf.sv
divNormalize.sv
divDigitSelect.sv
divOnTheFly.sv
divStage.sv
divider.sv
divClockGen.sv
divider_asserts.sv
dividerTb.sv
